// File: chart_loader.f
+incdir+hw
hw/sd_pkg.sv
hw/game_pkg.sv
hw/sd_byte_if.sv
hw/sd_sector_reader.sv
hw/metadata_store.sv
hw/song_clock.sv
hw/chart_loader_top.sv
dv/sd_card_model.sv
dv/chart_loader_tb.sv

// File: Makefile
# Verilator build and run of the chart loader testbench

SIM := obj_dir/Vchart_loader_tb

all: run

# Rebuilt only when a source or the file list changes
$(SIM): chart_loader.f $(wildcard hw/*.sv hw/*.svh dv/*.sv)
	verilator --binary --timing -j 0 --top-module chart_loader_tb -f chart_loader.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: dv/chart_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "chart_loader_defines.svh"

module chart_loader_tb;

    logic        clk25 = 1'b0;
    logic        reset;
    logic        load;
    logic [31:0] sector;
    logic        play;
    logic        pause;
    logic        restart;
    logic [3:0]  dbg_addr;
    logic [31:0] dbg_word;
    logic        loaded;
    logic        load_error;
    logic [15:0] song_time;
    logic        playing;
    logic        song_done;
    logic        spi_cs;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic [7:0]  r1_value;      // Card answer for the next read
    logic [7:0]  pattern_base;
    logic [7:0]  cmd_opcode;
    logic [31:0] cmd_address;

    always #10 clk25 = ~clk25;  // 20 ns period

    chart_loader_top DUT (.*);

    sd_card_model card (
        .cs           (spi_cs),
        .sck          (spi_sck),
        .mosi         (spi_mosi),
        .miso         (spi_miso),
        .r1_value     (r1_value),
        .pattern_base (pattern_base),
        .cmd_opcode   (cmd_opcode),
        .cmd_address  (cmd_address)
    );

    ////////////////////////////////////////////////////////////
    // Checking and waiting

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $fatal(1, "Timeout");
    endtask

    // Big-endian word k of the card pattern
    function automatic logic [31:0] pattern_word(input logic [7:0] base, input logic [3:0] idx);
        logic [7:0] b;
        b = base + {2'b00, idx, 2'b00};
        pattern_word = {b, b + 8'd1, b + 8'd2, b + 8'd3};
    endfunction

    task automatic run_load(input logic [31:0] addr, input logic [7:0] base,
                            input logic [7:0] r1);
        int cycles;
        sector       = addr;
        pattern_base = base;
        r1_value     = r1;
        load         = 1'b1;
        @(negedge clk25);
        load   = 1'b0;
        cycles = 0;
        while (!loaded && !load_error) begin  // Either level ends the read
            @(negedge clk25);
            cycles++;
            if (cycles > 100000)
                abort_on_timeout("the sector read to finish");
        end
    endtask

    task automatic read_word(input logic [3:0] addr, output logic [31:0] word);
        dbg_addr = addr;
        @(negedge clk25);  // One cycle read latency
        word = dbg_word;
    endtask

    task automatic press_play();
        play = 1'b1;
        @(negedge clk25);
        play = 1'b0;
    endtask

    // Cycles until song_time moves, which must be one step up
    task automatic measure_step(output int cycles);
        logic [15:0] from;
        from   = song_time;
        cycles = 0;
        while (song_time == from) begin
            @(negedge clk25);
            cycles++;
            if (cycles > 4 * `TICK_CYCLES)
                abort_on_timeout("song_time to advance");
        end
        check_eq("song_time", 32'(song_time), 32'(from) + 1);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic check_reset_state();
        check_eq("loaded", 32'(loaded), 0);
        check_eq("load_error", 32'(load_error), 0);
        check_eq("playing", 32'(playing), 0);
        check_eq("song_done", 32'(song_done), 0);
        check_eq("song_time", 32'(song_time), 0);
        check_eq("spi_cs", 32'(spi_cs), 1);
        check_eq("spi_sck", 32'(spi_sck), 0);
    endtask

    task automatic load_and_verify_words(input logic [31:0] addr, input logic [7:0] base);
        logic [31:0] word;
        run_load(addr, base, sd_pkg::R1_READY);
        check_eq("loaded", 32'(loaded), 1);
        check_eq("load_error", 32'(load_error), 0);
        check_eq("cmd_opcode", 32'(cmd_opcode), 32'(sd_pkg::CMD_READ_SINGLE));
        check_eq("cmd_address", cmd_address, addr);
        for (int k = 0; k < `META_WORDS; k++) begin
            read_word(4'(k), word);
            check_eq($sformatf("dbg_word[%0d]", k), word, pattern_word(base, 4'(k)));
        end
    endtask

    task automatic read_error_recovery(input logic [31:0] addr, input logic [7:0] base);
        run_load(addr, base, 8'h04);                 // Illegal command flag
        check_eq("load_error", 32'(load_error), 1);
        check_eq("loaded", 32'(loaded), 0);
        repeat (`TICK_CYCLES) @(negedge clk25);
        check_eq("loaded", 32'(loaded), 0);          // Stays down after a bad read
        run_load(addr, base, sd_pkg::R1_READY);
        check_eq("load_error", 32'(load_error), 0);
        check_eq("loaded", 32'(loaded), 1);
    endtask

    task automatic song_length_timing(input logic [31:0] addr);
        logic [31:0] word;
        int          cycles;
        run_load(addr, 8'hFE, sd_pkg::R1_READY);     // Bytes FE FF 00 01, length 1
        read_word(game_pkg::META_SONG_LENGTH, word);
        check_eq("song length word", word, pattern_word(8'hFE, game_pkg::META_SONG_LENGTH));
        read_word(game_pkg::META_BPM, word);
        check_eq("bpm word", word, pattern_word(8'hFE, game_pkg::META_BPM));
        repeat (4) @(negedge clk25);                 // Length fetch
        press_play();
        check_eq("playing", 32'(playing), 1);
        measure_step(cycles);
        check_eq("tick cycles", 32'(cycles), `TICK_CYCLES);
        check_eq("song_done", 32'(song_done), 1);
        check_eq("playing", 32'(playing), 0);
        repeat (2 * `TICK_CYCLES) @(negedge clk25);
        check_eq("song_time at end", 32'(song_time), 1);
        check_eq("song_done", 32'(song_done), 1);
    endtask

    task automatic pause_and_restart(input logic [31:0] addr, input logic [7:0] base);
        logic [15:0] held;
        int          cycles;
        run_load(addr, base, sd_pkg::R1_READY);      // Length 0x0203 or more
        repeat (4) @(negedge clk25);
        press_play();
        for (int n = 0; n < 4; n++) begin
            measure_step(cycles);
            check_eq("tick cycles", 32'(cycles), `TICK_CYCLES);
        end
        held  = song_time;
        pause = 1'b1;
        @(negedge clk25);
        for (int n = 0; n < 10 * `TICK_CYCLES; n++) begin
            check_eq("song_time while paused", 32'(song_time), 32'(held));
            check_eq("playing while paused", 32'(playing), 0);
            @(negedge clk25);
        end
        pause = 1'b0;
        measure_step(cycles);                        // Count picks up again
        check_eq("playing", 32'(playing), 1);
        restart = 1'b1;
        @(negedge clk25);
        restart = 1'b0;
        check_eq("song_time after restart", 32'(song_time), 0);
        check_eq("playing", 32'(playing), 0);
        check_eq("song_done", 32'(song_done), 0);
        repeat (2 * `TICK_CYCLES) @(negedge clk25);
        check_eq("song_time in ready", 32'(song_time), 0);
        press_play();
        measure_step(cycles);
        check_eq("tick cycles", 32'(cycles), `TICK_CYCLES);
    endtask

    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] addr;
        logic [7:0]  base;
        void'($urandom(32'h859a));
        reset        = 1'b1;
        load         = 1'b0;
        sector       = '0;
        play         = 1'b0;
        pause        = 1'b0;
        restart      = 1'b0;
        dbg_addr     = '0;
        r1_value     = sd_pkg::R1_READY;
        pattern_base = '0;
        repeat (4) @(negedge clk25);
        reset = 1'b0;
        addr  = $urandom();
        base  = 8'($urandom_range(253));  // Keeps the song length large
        check_reset_state();
        load_and_verify_words(addr, base);
        read_error_recovery(addr, base);
        song_length_timing(addr);
        addr = $urandom();
        base = 8'($urandom_range(253));
        pause_and_restart(addr, base);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "chart_loader_defines.svh"

// SPI-mode SD card that answers one single-block read per CS frame
module sd_card_model (
    input  wire logic        cs,
    input  wire logic        sck,
    input  wire logic        mosi,
    output logic             miso,
    input  wire logic [7:0]  r1_value,      // R1 sent back for the read
    input  wire logic [7:0]  pattern_base,  // Sector byte i is base + i
    output logic [7:0]       cmd_opcode,    // First command byte seen
    output logic [31:0]      cmd_address    // Address bytes, MSB first
);

    logic [7:0] rx_shift;
    int         rx_bits;
    int         rx_count;         // Bytes received in this frame
    logic [7:0] reply [$];        // Bytes queued after the command
    logic [7:0] tx_shift;
    int         tx_bits;
    int         tx_ptr;

    assign miso = tx_shift[7];

    ////////////////////////////////////////////////////////////
    // Host to card, sampled on the rising edge
    always @(posedge sck or posedge cs) begin
        if (cs) begin
            rx_bits  = 0;         // Frame over
            rx_count = 0;
            reply.delete();
        end else begin
            rx_shift = {rx_shift[6:0], mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == 8) begin
                rx_bits = 0;
                case (rx_count)
                    0:          cmd_opcode = rx_shift;
                    1, 2, 3, 4: cmd_address = {cmd_address[23:0], rx_shift};
                    5: if (cmd_opcode == sd_pkg::CMD_READ_SINGLE) begin
                        reply.push_back(sd_pkg::FILL);       // Ncr gap
                        reply.push_back(r1_value);
                        if (r1_value == sd_pkg::R1_READY) begin
                            reply.push_back(sd_pkg::FILL);   // Access delay
                            reply.push_back(sd_pkg::FILL);
                            reply.push_back(sd_pkg::TOKEN_DATA);
                            for (int i = 0; i < `SECTOR_BYTES; i++)
                                reply.push_back(pattern_base + 8'(i));
                            reply.push_back(8'hC3);          // CRC, never checked
                            reply.push_back(8'h3C);
                        end
                    end
                    default: ;
                endcase
                rx_count = rx_count + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Card to host, next bit on the falling edge
    always @(negedge sck or posedge cs) begin
        if (cs) begin
            tx_shift = sd_pkg::FILL;  // Line idles high
            tx_bits  = 0;
            tx_ptr   = 0;
        end else begin
            tx_bits = tx_bits + 1;
            if (tx_bits == 8) begin
                tx_bits = 0;
                if (tx_ptr < reply.size()) begin
                    tx_shift = reply[tx_ptr];
                    tx_ptr   = tx_ptr + 1;
                end else begin
                    tx_shift = sd_pkg::FILL;    // Nothing queued
                end
            end else begin
                tx_shift = {tx_shift[6:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/chart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module chart_loader_top (
    input  wire logic        clk25,
    input  wire logic        reset,
    input  wire logic        load,
    input  wire logic [31:0] sector,
    input  wire logic        play,
    input  wire logic        pause,
    input  wire logic        restart,
    input  wire logic [3:0]  dbg_addr,
    output logic [31:0]      dbg_word,
    output logic             loaded,
    output logic             load_error,
    output logic [15:0]      song_time,
    output logic             playing,
    output logic             song_done,
    output logic             spi_cs,
    output logic             spi_sck,
    output logic             spi_mosi,
    input  wire logic        spi_miso
);

    logic [3:0]  meta_addr;  // Song clock read port into the store
    logic [31:0] meta_word;

    sd_byte_if sd_bus ();

    ////////////////////////////////////////////////////////////
    // Producer, buffer, consumer

    sd_sector_reader u_reader (
        .clk25    (clk25),
        .reset    (reset),
        .bus      (sd_bus.source),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    metadata_store u_store (
        .clk25      (clk25),
        .reset      (reset),
        .load       (load),
        .sector     (sector),
        .bus        (sd_bus.sink),
        .rd_addr    (meta_addr),
        .rd_word    (meta_word),
        .dbg_addr   (dbg_addr),
        .dbg_word   (dbg_word),
        .loaded     (loaded),
        .load_error (load_error)
    );

    song_clock u_clock (
        .clk25     (clk25),
        .reset     (reset),
        .loaded    (loaded),    // Also drives the top output
        .pause     (pause),
        .restart   (restart),
        .meta_addr (meta_addr),
        .meta_word (meta_word),
        .play      (play),
        .song_time (song_time),
        .playing   (playing),
        .song_done (song_done)
    );

endmodule

`default_nettype wire

// File: hw/song_clock.sv
`timescale 1ns/1ps
`default_nettype none

`include "chart_loader_defines.svh"

module song_clock (
    input  wire logic        clk25,
    input  wire logic        reset,
    input  wire logic        loaded,
    input  wire logic        pause,
    input  wire logic        restart,
    output logic [3:0]       meta_addr,
    input  wire logic [31:0] meta_word,
    input  wire logic        play,
    output logic [15:0]      song_time,
    output logic             playing,
    output logic             song_done
);

    localparam int TICK_W = $clog2(`TICK_CYCLES);

    game_pkg::song_state_e state;
    logic [TICK_W-1:0]     tick_cnt;
    logic [15:0]           song_len;
    logic                  fetch_wait;  // Store read still in flight

    assign playing   = (state == game_pkg::PLAYING);
    assign song_done = (state == game_pkg::DONE);

    always_ff @(posedge clk25) begin
        if (reset) begin
            state      <= game_pkg::WAIT_LOAD;
            meta_addr  <= '0;
            tick_cnt   <= '0;
            song_time  <= '0;
            fetch_wait <= 1'b0;
        end else if (state != game_pkg::WAIT_LOAD && !loaded) begin
            state     <= game_pkg::WAIT_LOAD;  // Metadata being reloaded
            tick_cnt  <= '0;
            song_time <= '0;
        end else if (restart && state != game_pkg::WAIT_LOAD && state != game_pkg::FETCH) begin
            state     <= game_pkg::READY;
            tick_cnt  <= '0;
            song_time <= '0;
        end else begin
            case (state)
                game_pkg::WAIT_LOAD: if (loaded) begin
                    meta_addr  <= game_pkg::META_SONG_LENGTH;
                    fetch_wait <= 1'b1;
                    state      <= game_pkg::FETCH;
                end
                game_pkg::FETCH: begin
                    if (fetch_wait) begin
                        fetch_wait <= 1'b0;
                    end else begin
                        song_len <= meta_word[15:0];  // Length in ticks
                        state    <= game_pkg::READY;
                    end
                end
                game_pkg::READY: if (play) begin
                    state <= (song_time == song_len) ? game_pkg::DONE : game_pkg::PLAYING;
                end
                game_pkg::PLAYING: begin
                    if (pause) begin
                        state <= game_pkg::PAUSED;        // Tick count frozen
                    end else if (tick_cnt == TICK_W'(`TICK_CYCLES - 1)) begin
                        tick_cnt  <= '0;
                        song_time <= song_time + 16'd1;
                        if (song_time + 16'd1 == song_len)
                            state <= game_pkg::DONE;
                    end else begin
                        tick_cnt <= tick_cnt + TICK_W'(1);
                    end
                end
                game_pkg::PAUSED: if (!pause) state <= game_pkg::PLAYING;
                game_pkg::DONE: ;                         // Hold until restart or reload
                default: state <= game_pkg::WAIT_LOAD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/metadata_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "chart_loader_defines.svh"

module metadata_store (
    input  wire logic        clk25,
    input  wire logic        reset,
    input  wire logic        load,        // Fetch a new sector
    input  wire logic [31:0] sector,
    sd_byte_if.sink          bus,
    input  wire logic [3:0]  rd_addr,     // Game side read port
    output logic [31:0]      rd_word,
    input  wire logic [3:0]  dbg_addr,    // Debug read port
    output logic [31:0]      dbg_word,
    output logic             loaded,
    output logic             load_error
);

    logic [31:0] mem [0:`META_WORDS-1];
    logic [23:0] word_sr;      // First three bytes of the current word
    logic [1:0]  lane_cnt;     // Byte position within the word
    logic [3:0]  word_cnt;
    logic        store_full;   // Remaining sector bytes are dropped

    logic take_load;           // Load honored only while the engine is idle
    logic take_byte;
    assign take_load = load && !bus.busy;
    assign take_byte = bus.valid && !store_full && !take_load;

    // Control
    always_ff @(posedge clk25) begin
        if (reset) begin
            bus.start  <= 1'b0;
            lane_cnt   <= '0;
            word_cnt   <= '0;
            store_full <= 1'b0;
            loaded     <= 1'b0;
            load_error <= 1'b0;
        end else begin
            bus.start <= take_load;  // Request goes out the cycle after load
            if (take_load) begin
                loaded     <= 1'b0;
                load_error <= 1'b0;
                lane_cnt   <= '0;
                word_cnt   <= '0;
                store_full <= 1'b0;
            end else begin
                if (take_byte) begin
                    lane_cnt <= lane_cnt + 2'd1;
                    if (lane_cnt == 2'd3) begin
                        word_cnt <= word_cnt + 4'd1;
                        if (word_cnt == 4'(`META_WORDS - 1))
                            store_full <= 1'b1;
                    end
                end
                if (bus.done) begin
                    if (bus.error)
                        load_error <= 1'b1;
                    else
                        loaded <= 1'b1;
                end
            end
        end
    end

    // Address and word assembly, big-endian
    always_ff @(posedge clk25) begin
        if (take_load)
            bus.address <= sector;  // Stable for the whole read
        if (take_byte) begin
            word_sr <= {word_sr[15:0], bus.data};
            if (lane_cnt == 2'd3)
                mem[word_cnt] <= {word_sr, bus.data};  // Byte 4k lands in [31:24]
        end
    end

    // Two synchronous read ports
    always_ff @(posedge clk25) begin
        rd_word  <= mem[rd_addr];
        dbg_word <= mem[dbg_addr];
    end

endmodule

`default_nettype wire

// File: hw/sd_sector_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "chart_loader_defines.svh"

module sd_sector_reader (
    input  wire logic  clk25,
    input  wire logic  reset,
    sd_byte_if.source  bus,
    output logic       spi_cs,
    output logic       spi_sck,
    output logic       spi_mosi,
    input  wire logic  spi_miso
);

    localparam int DIV_W = $clog2(`SPI_DIV);

    sd_pkg::sd_state_e state;
    logic [9:0]        byte_cnt;   // Command index, poll count or data index
    logic              load_byte;  // Kick the shifter with tx_byte
    logic [7:0]        tx_byte;
    logic [7:0]        tx_shift;
    logic [7:0]        rx_shift;
    logic [DIV_W-1:0]  div_cnt;
    logic [2:0]        bit_cnt;
    logic              xfer_busy;
    logic              byte_done;  // rx_shift holds a full byte

    // Command frame byte by index
    function automatic logic [7:0] cmd_byte(input logic [2:0] idx, input logic [31:0] addr);
        case (idx)
            3'd0:    cmd_byte = sd_pkg::CMD_READ_SINGLE;
            3'd1:    cmd_byte = addr[31:24];  // MSB first
            3'd2:    cmd_byte = addr[23:16];
            3'd3:    cmd_byte = addr[15:8];
            3'd4:    cmd_byte = addr[7:0];
            default: cmd_byte = sd_pkg::FILL; // No CRC in SPI mode
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Byte shifter, mode 0

    assign spi_mosi = tx_shift[7];

    always_ff @(posedge clk25) begin
        if (reset) begin
            xfer_busy <= 1'b0;
            spi_sck   <= 1'b0;                      // SCK idles low
            div_cnt   <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            tx_shift  <= sd_pkg::FILL;              // MOSI idles high
        end else begin
            byte_done <= 1'b0;
            if (load_byte) begin
                xfer_busy <= 1'b1;
                div_cnt   <= '0;
                bit_cnt   <= '0;
                tx_shift  <= tx_byte;               // Bit 7 out before first rise
            end else if (xfer_busy) begin
                if (div_cnt == DIV_W'(`SPI_DIV - 1)) begin
                    div_cnt <= '0;
                    if (!spi_sck) begin
                        spi_sck <= 1'b1;            // Rising edge, sample
                    end else begin
                        spi_sck <= 1'b0;            // Falling edge, next bit
                        if (bit_cnt == 3'd7) begin
                            xfer_busy <= 1'b0;
                            byte_done <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 3'd1;
                            tx_shift <= {tx_shift[6:0], 1'b1};
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + DIV_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (xfer_busy && !spi_sck && div_cnt == DIV_W'(`SPI_DIV - 1))
            rx_shift <= {rx_shift[6:0], spi_miso};  // MSB arrives first
    end

    ////////////////////////////////////////////////////////////
    // Read sequencer

    always_ff @(posedge clk25) begin
        if (reset) begin
            state     <= sd_pkg::IDLE;
            byte_cnt  <= '0;
            load_byte <= 1'b0;
            spi_cs    <= 1'b1;
            bus.busy  <= 1'b0;
            bus.valid <= 1'b0;
            bus.done  <= 1'b0;
            bus.error <= 1'b0;
        end else begin
            load_byte <= 1'b0;
            tx_byte   <= sd_pkg::FILL;  // Dummy byte unless sending the command
            bus.valid <= 1'b0;
            bus.done  <= 1'b0;
            case (state)
                sd_pkg::IDLE: if (bus.start) begin
                    spi_cs    <= 1'b0;
                    bus.busy  <= 1'b1;
                    bus.error <= 1'b0;
                    byte_cnt  <= '0;
                    tx_byte   <= cmd_byte(3'd0, bus.address);
                    load_byte <= 1'b1;
                    state     <= sd_pkg::SEND_CMD;
                end
                sd_pkg::SEND_CMD: if (byte_done) begin
                    load_byte <= 1'b1;
                    if (byte_cnt == 10'd5) begin
                        byte_cnt <= '0;
                        state    <= sd_pkg::WAIT_R1;
                    end else begin
                        byte_cnt <= byte_cnt + 10'd1;
                        tx_byte  <= cmd_byte(byte_cnt[2:0] + 3'd1, bus.address);
                    end
                end
                sd_pkg::WAIT_R1: if (byte_done) begin
                    if (rx_shift == sd_pkg::R1_READY) begin
                        byte_cnt  <= '0;
                        load_byte <= 1'b1;
                        state     <= sd_pkg::WAIT_TOKEN;
                    end else if (rx_shift != sd_pkg::FILL ||
                                 byte_cnt == 10'(`R1_TRIES - 1)) begin
                        bus.error <= 1'b1;                  // Error flags or no answer
                        state     <= sd_pkg::FINISH;
                    end else begin
                        byte_cnt  <= byte_cnt + 10'd1;
                        load_byte <= 1'b1;
                    end
                end
                sd_pkg::WAIT_TOKEN: if (byte_done) begin
                    if (rx_shift == sd_pkg::TOKEN_DATA) begin
                        byte_cnt  <= '0;
                        load_byte <= 1'b1;
                        state     <= sd_pkg::READ_DATA;
                    end else if (rx_shift != sd_pkg::FILL ||
                                 byte_cnt == 10'(`TOKEN_TRIES - 1)) begin
                        bus.error <= 1'b1;                  // Error token or timeout
                        state     <= sd_pkg::FINISH;
                    end else begin
                        byte_cnt  <= byte_cnt + 10'd1;
                        load_byte <= 1'b1;
                    end
                end
                sd_pkg::READ_DATA: if (byte_done) begin
                    bus.data  <= rx_shift;
                    bus.valid <= 1'b1;
                    load_byte <= 1'b1;
                    if (byte_cnt == 10'(`SECTOR_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= sd_pkg::READ_CRC;
                    end else begin
                        byte_cnt <= byte_cnt + 10'd1;
                    end
                end
                sd_pkg::READ_CRC: if (byte_done) begin
                    if (byte_cnt == 10'd1) begin
                        state <= sd_pkg::FINISH;            // CRC ignored
                    end else begin
                        byte_cnt  <= byte_cnt + 10'd1;
                        load_byte <= 1'b1;
                    end
                end
                sd_pkg::FINISH: begin
                    spi_cs   <= 1'b1;
                    bus.busy <= 1'b0;
                    bus.done <= 1'b1;
                    state    <= sd_pkg::IDLE;
                end
                default: state <= sd_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/sd_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

// Sector request in one direction, byte stream back in the other
interface sd_byte_if;

    logic        start;    // One-cycle request, honored while not busy
    logic [31:0] address;  // Held stable during busy
    logic        busy;
    logic [7:0]  data;     // Qualified by valid
    logic        valid;    // One pulse per sector byte
    logic        done;     // End of read, good or bad
    logic        error;    // Held until the next start

    // SD read engine side
    modport source (
        input  start, address,
        output busy, data, valid, done, error
    );

    // Word assembler side
    modport sink (
        output start, address,
        input  busy, data, valid, done, error
    );

endinterface

`default_nettype wire

// File: hw/game_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Gameplay side
////////////////////////////////////////////////////////////

package game_pkg;

    typedef enum logic [2:0] {
        WAIT_LOAD = 3'd0,  // No metadata yet
        FETCH     = 3'd1,  // Reading song length from the store
        READY     = 3'd2,  // Length known, waiting for play
        PLAYING   = 3'd3,
        PAUSED    = 3'd4,
        DONE      = 3'd5   // Song time reached the length
    } song_state_e;

    // Word slots at the head of the chart sector
    typedef enum logic [3:0] {
        META_SONG_LENGTH = 4'd0,  // Low 16 bits used as song length
        META_BPM         = 4'd1,
        META_OFFSET      = 4'd2
    } meta_index_e;

endpackage

`default_nettype wire

// File: hw/sd_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// SD card transport over SPI
////////////////////////////////////////////////////////////

package sd_pkg;

    // Read engine sequence for one single-block read
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // CS high, waiting for start
        SEND_CMD   = 3'd1,  // Opcode, 4 address bytes, CRC stand-in
        WAIT_R1    = 3'd2,  // Poll for the R1 response
        WAIT_TOKEN = 3'd3,  // Poll for the start-of-data token
        READ_DATA  = 3'd4,  // Sector payload
        READ_CRC   = 3'd5,  // Two CRC bytes, thrown away
        FINISH     = 3'd6   // Release CS, pulse done
    } sd_state_e;

    // Byte values seen on the wire
    typedef enum logic [7:0] {
        CMD_READ_SINGLE = 8'h51,  // CMD17 with start and transmit bits
        R1_READY        = 8'h00,  // R1 with no error flags
        TOKEN_DATA      = 8'hFE,  // Start block token
        FILL            = 8'hFF   // Idle line / dummy byte
    } sd_opcode_e;

endpackage

`default_nettype wire

// File: hw/chart_loader_defines.svh
`ifndef CHART_LOADER_DEFINES_SVH
`define CHART_LOADER_DEFINES_SVH

// Sector geometry
`define SECTOR_BYTES 512
`define META_WORDS   16      // Store depth, 4-bit word address

// SPI timing, clk25 cycles per half SCK period
`define SPI_DIV      4

// Poll limits, counted in bytes
`define R1_TRIES     8
`define TOKEN_TRIES  256

// Song clock resolution in clk25 cycles
`define TICK_CYCLES  25

`endif
